// File: build.f
+incdir+verilog
verilog/md_pkg.sv
verilog/md_itf.sv
verilog/md_rs.sv
verilog/md_prf.sv
verilog/md_ctrl.sv
verilog/md_cycle_counter.sv
verilog/md_datapath.sv
verilog/md_top.sv
verification/md_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the md_tb simulation, verdict comes from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module md_tb -o md_sim \
    > sim.log 2>&1 \
    && ./obj_dir/md_sim >> sim.log 2>&1 \
    || echo "Simulation FAILED" >> sim.log

cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

// File: verification/md_tb.sv
`timescale 1ns/1ps
`include "md_macros.svh"

module md_tb
    import md_pkg::*;
();

    localparam int NUM_TESTS = 5;
    localparam int LIMIT = NUM_TESTS * `MD_RS_DEPTH * (`MD_XLEN + 10);

    logic clk;
    logic rst;
    logic ds_valid;
    logic ds_ready;
    md_op_e ds_op;
    logic [`MD_PHY_BITS-1:0] ds_rs1_phy;
    logic ds_rs1_ready;
    logic [`MD_PHY_BITS-1:0] ds_rs2_phy;
    logic ds_rs2_ready;
    logic [`MD_PHY_BITS-1:0] ds_rd_phy;
    logic [`MD_ROB_BITS-1:0] ds_rob_id;
    logic ext_valid;
    logic [`MD_PHY_BITS-1:0] ext_rd_phy;
    logic [`MD_XLEN-1:0] ext_value;
    logic md_valid;
    logic md_ready;
    logic [`MD_PHY_BITS-1:0] md_rd_phy;
    logic [`MD_ROB_BITS-1:0] md_rob_id;
    logic [`MD_XLEN-1:0] md_value;

    // values the testbench has put into each physical register
    logic [`MD_XLEN-1:0] shadow [2**`MD_PHY_BITS];
    integer seed = 32'h16c5_2e1d;

    md_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // reference model and checks
    // ------------------------------
    function automatic logic [`MD_XLEN-1:0] ref_result(md_op_e op, logic [31:0] a,
                                                      logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] r;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        r = '0;
        case (op)
            MD_MUL:    r = sa * sb;
            MD_MULH:   r = (sa * sb) >>> 32;
            MD_MULHSU: r = (sa * $signed({32'b0, b})) >>> 32;
            MD_MULHU:  r = ({32'b0, a} * {32'b0, b}) >> 32;
            MD_DIV: begin
                if (b == '0) begin
                    r = '1;
                end else if (a == 32'h8000_0000 && b == '1) begin
                    r = {32'b0, a};
                end else begin
                    r = sa / sb;
                end
            end
            MD_DIVU:   r = (b == '0) ? '1 : {32'b0, a / b};
            MD_REM: begin
                if (b == '0) begin
                    r = {32'b0, a};
                end else if (a == 32'h8000_0000 && b == '1) begin
                    r = '0;
                end else begin
                    r = sa % sb;
                end
            end
            default:   r = (b == '0) ? {32'b0, a} : {32'b0, a % b};
        endcase
        return r[31:0];
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(string test, logic [`MD_XLEN-1:0] exp, logic [`MD_XLEN-1:0] act);
        if (exp !== act) begin
            abort_run($sformatf("FAIL %s: expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic check_tag(string test, logic [`MD_PHY_BITS-1:0] exp_rd,
                             logic [`MD_ROB_BITS-1:0] exp_rob,
                             logic [`MD_PHY_BITS-1:0] act_rd, logic [`MD_ROB_BITS-1:0] act_rob);
        if ({exp_rd, exp_rob} !== {act_rd, act_rob}) begin
            abort_run($sformatf("FAIL %s: expected rd %0d rob %0d, actual rd %0d rob %0d",
                                test, exp_rd, exp_rob, act_rd, act_rob));
        end
    endtask

    task automatic check_op_result(string test, md_op_e op, logic [31:0] a, logic [31:0] b,
                                   logic [`MD_PHY_BITS-1:0] exp_rd,
                                   logic [`MD_ROB_BITS-1:0] exp_rob,
                                   logic [`MD_PHY_BITS-1:0] act_rd,
                                   logic [`MD_ROB_BITS-1:0] act_rob, logic [31:0] act_val);
        check_tag($sformatf("%s %s", test, op.name()), exp_rd, exp_rob, act_rd, act_rob);
        check_value($sformatf("%s %s", test, op.name()), ref_result(op, a, b), act_val);
    endtask

    // ------------------------------
    // bus drivers
    // ------------------------------
    task automatic ext_write(logic [`MD_PHY_BITS-1:0] phy, logic [`MD_XLEN-1:0] val);
        @(posedge clk);
        ext_valid <= 1'b1;
        ext_rd_phy <= phy;
        ext_value <= val;
        shadow[phy] = val;
        @(posedge clk);
        ext_valid <= 1'b0;
    endtask

    task automatic dispatch(md_op_e op, logic [4:0] rs1, logic r1, logic [4:0] rs2, logic r2,
                            logic [4:0] rd, logic [3:0] rob);
        @(posedge clk);
        ds_valid <= 1'b1;
        ds_op <= op;
        ds_rs1_phy <= rs1;
        ds_rs1_ready <= r1;
        ds_rs2_phy <= rs2;
        ds_rs2_ready <= r2;
        ds_rd_phy <= rd;
        ds_rob_id <= rob;
        @(negedge clk);
        while (!ds_ready) @(negedge clk);
        @(posedge clk);
        ds_valid <= 1'b0;
    endtask

    // waits for md_valid and consumes it only when md_ready is high
    task automatic collect_result(output logic [4:0] rd, output logic [3:0] rob,
                                  output logic [31:0] val);
        @(negedge clk);
        while (!md_valid) @(negedge clk);
        rd = md_rd_phy;
        rob = md_rob_id;
        val = md_value;
        if (md_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic run_op(string test, md_op_e op, logic [4:0] rs1, logic [4:0] rs2,
                          logic [4:0] rd, logic [3:0] rob);
        logic [4:0] a_rd;
        logic [3:0] a_rob;
        logic [31:0] a_val;
        dispatch(op, rs1, 1'b1, rs2, 1'b1, rd, rob);
        collect_result(a_rd, a_rob, a_val);
        check_op_result(test, op, shadow[rs1], shadow[rs2], rd, rob, a_rd, a_rob, a_val);
        shadow[rd] = ref_result(op, shadow[rs1], shadow[rs2]);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_mul();
        ext_write(5'd1, $random(seed));
        ext_write(5'd2, $random(seed));
        run_op("test_mul", MD_MUL, 5'd1, 5'd2, 5'd25, 4'd1);
        run_op("test_mul", MD_MULH, 5'd1, 5'd2, 5'd26, 4'd2);
        run_op("test_mul", MD_MULHSU, 5'd1, 5'd2, 5'd27, 4'd3);
        run_op("test_mul", MD_MULHU, 5'd1, 5'd2, 5'd28, 4'd4);
    endtask

    task automatic test_div();
        ext_write(5'd3, $random(seed));
        ext_write(5'd4, $random(seed));
        ext_write(5'd5, '0);
        ext_write(5'd6, 32'h8000_0000);
        ext_write(5'd7, 32'hffff_ffff);
        run_op("test_div", MD_DIV, 5'd3, 5'd4, 5'd25, 4'd5);
        run_op("test_div", MD_DIVU, 5'd3, 5'd4, 5'd26, 4'd6);
        run_op("test_div", MD_REM, 5'd3, 5'd4, 5'd27, 4'd7);
        run_op("test_div", MD_REMU, 5'd3, 5'd4, 5'd28, 4'd8);
        // divide by zero, then signed overflow
        run_op("test_div zero", MD_DIV, 5'd3, 5'd5, 5'd25, 4'd9);
        run_op("test_div zero", MD_REMU, 5'd3, 5'd5, 5'd26, 4'd10);
        run_op("test_div ovf", MD_DIV, 5'd6, 5'd7, 5'd27, 4'd11);
        run_op("test_div ovf", MD_REM, 5'd6, 5'd7, 5'd28, 4'd12);
    endtask

    task automatic test_wakeup();
        logic [4:0] a_rd;
        logic [3:0] a_rob;
        logic [31:0] a_val;
        dispatch(MD_MUL, 5'd10, 1'b0, 5'd2, 1'b1, 5'd29, 4'd13);
        // long enough for an early issue to reach md_valid
        repeat (`MD_XLEN + 4) begin
            @(negedge clk);
            if (md_valid) begin
                abort_run("test_wakeup: result appeared before its source was broadcast");
            end
        end
        ext_write(5'd10, $random(seed));
        collect_result(a_rd, a_rob, a_val);
        check_op_result("test_wakeup", MD_MUL, shadow[10], shadow[2], 5'd29, 4'd13,
                        a_rd, a_rob, a_val);
    endtask

    task automatic test_backpressure();
        logic [4:0] a_rd;
        logic [3:0] a_rob;
        logic [31:0] a_val;
        int hold;
        hold = 2 + ($unsigned($random(seed)) % 8);
        @(posedge clk);
        md_ready <= 1'b0;
        dispatch(MD_MULHSU, 5'd1, 1'b1, 5'd3, 1'b1, 5'd30, 4'd14);
        collect_result(a_rd, a_rob, a_val);
        repeat (hold) begin
            @(negedge clk);
            if (!md_valid || md_rd_phy !== a_rd || md_rob_id !== a_rob || md_value !== a_val) begin
                abort_run("test_backpressure: result changed while md_ready was low");
            end
        end
        @(posedge clk);
        md_ready <= 1'b1;
        @(posedge clk);
        repeat (3) begin
            @(negedge clk);
            if (md_valid) begin
                abort_run("test_backpressure: result delivered more than once");
            end
        end
        check_op_result("test_backpressure", MD_MULHSU, shadow[1], shadow[3], 5'd30, 4'd14,
                        a_rd, a_rob, a_val);
    endtask

    task automatic test_fill_chain();
        md_op_e ops [4] = '{MD_MUL, MD_MULHU, MD_DIVU, MD_MUL};
        logic [4:0] rs1 [4] = '{5'd1, 5'd3, 5'd3, 5'd20};
        logic [4:0] rds [4] = '{5'd20, 5'd22, 5'd23, 5'd24};
        logic [31:0] opa [4];
        logic [3:0] seen;
        logic [4:0] a_rd;
        logic [3:0] a_rob;
        logic [31:0] a_val;
        int k;
        seen = '0;
        @(posedge clk);
        md_ready <= 1'b0;
        // every entry waits on p21 and the last one also on the first result
        for (int i = 0; i < `MD_RS_DEPTH; i++) begin
            @(negedge clk);
            if (!ds_ready) begin
                abort_run($sformatf("test_fill_chain: ds_ready dropped after %0d accepts", i));
            end
            dispatch(ops[i], rs1[i], (i != 3), 5'd21, 1'b0, rds[i], 4'(8 + i));
        end
        @(negedge clk);
        if (ds_ready) begin
            abort_run("test_fill_chain: ds_ready still high with the station full");
        end
        @(posedge clk);
        md_ready <= 1'b1;
        ext_write(5'd21, $random(seed) | 32'h1);
        for (int i = 0; i < 3; i++) begin
            opa[i] = shadow[rs1[i]];
        end
        opa[3] = ref_result(ops[0], opa[0], shadow[21]);
        for (int n = 0; n < `MD_RS_DEPTH; n++) begin
            collect_result(a_rd, a_rob, a_val);
            k = int'(a_rob) - 8;
            if (k < 0 || k > 3 || seen[k]) begin
                abort_run($sformatf("test_fill_chain: unexpected or repeated rob_id %0d", a_rob));
            end
            seen[k] = 1'b1;
            check_op_result("test_fill_chain", ops[k], opa[k], shadow[21], rds[k], 4'(8 + k),
                            a_rd, a_rob, a_val);
        end
    endtask

    // ------------------------------
    // sequence and watchdog
    // ------------------------------
    initial begin
        repeat (LIMIT) @(posedge clk);
        abort_run("watchdog: simulation hung, tests did not finish in time");
    end

    initial begin
        rst = 1'b1;
        ds_valid = 1'b0;
        ds_op = MD_MUL;
        ds_rs1_phy = '0;
        ds_rs1_ready = 1'b0;
        ds_rs2_phy = '0;
        ds_rs2_ready = 1'b0;
        ds_rd_phy = '0;
        ds_rob_id = '0;
        ext_valid = 1'b0;
        ext_rd_phy = '0;
        ext_value = '0;
        md_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_mul();
        test_div();
        test_wakeup();
        test_backpressure();
        test_fill_chain();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: verilog/md_top.sv
`timescale 1ns/1ps
`include "md_macros.svh"

module md_top
    import md_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     ds_valid,
    output logic                     ds_ready,
    input  md_op_e                   ds_op,
    input  logic [`MD_PHY_BITS-1:0]  ds_rs1_phy,
    input  logic                     ds_rs1_ready,
    input  logic [`MD_PHY_BITS-1:0]  ds_rs2_phy,
    input  logic                     ds_rs2_ready,
    input  logic [`MD_PHY_BITS-1:0]  ds_rd_phy,
    input  logic [`MD_ROB_BITS-1:0]  ds_rob_id,

    input  logic                     ext_valid,
    input  logic [`MD_PHY_BITS-1:0]  ext_rd_phy,
    input  logic [`MD_XLEN-1:0]      ext_value,

    output logic                     md_valid,
    input  logic                     md_ready,
    output logic [`MD_PHY_BITS-1:0]  md_rd_phy,
    output logic [`MD_ROB_BITS-1:0]  md_rob_id,
    output logic [`MD_XLEN-1:0]      md_value
);

    md_cdb_if       ext_cdb ();
    md_cdb_if       md_cdb ();
    md_issue_if     issue ();
    md_prf_read_if  prf_rd ();

    md_uop_t  ds_uop;
    logic     load;
    logic     step;
    logic     fix;
    logic     cnt_load;
    logic     cnt_en;
    logic     cnt_last;

    assign ds_uop = '{op: ds_op, rs1_phy: ds_rs1_phy, rs1_ready: ds_rs1_ready,
                      rs2_phy: ds_rs2_phy, rs2_ready: ds_rs2_ready,
                      rd_phy: ds_rd_phy, rob_id: ds_rob_id};

    // external bus never stalls
    assign ext_cdb.valid  = ext_valid;
    assign ext_cdb.ready  = 1'b1;
    assign ext_cdb.rd_phy = ext_rd_phy;
    assign ext_cdb.rob_id = '0;
    assign ext_cdb.value  = ext_value;

    assign md_cdb.ready = md_ready;
    assign md_valid     = md_cdb.valid;
    assign md_rd_phy    = md_cdb.rd_phy;
    assign md_rob_id    = md_cdb.rob_id;
    assign md_value     = md_cdb.value;

    md_rs u_rs (
        .clk(clk), .rst(rst), .ds_valid(ds_valid), .ds_uop(ds_uop), .ds_ready(ds_ready),
        .ext_cdb(ext_cdb), .md_cdb(md_cdb), .issue(issue), .prf(prf_rd)
    );

    md_prf u_prf (.clk(clk), .ext_cdb(ext_cdb), .md_cdb(md_cdb), .rd(prf_rd));

    md_ctrl u_ctrl (
        .clk(clk), .rst(rst), .issue(issue), .out(md_cdb), .load(load), .step(step),
        .fix(fix), .cnt_load(cnt_load), .cnt_en(cnt_en), .cnt_last(cnt_last)
    );

    md_cycle_counter u_cnt (
        .clk(clk), .rst(rst), .cnt_load(cnt_load), .cnt_en(cnt_en), .cnt_last(cnt_last)
    );

    md_datapath u_dp (
        .clk(clk), .issue(issue), .load(load), .step(step), .fix(fix), .out(md_cdb)
    );

endmodule

// File: verilog/md_datapath.sv
`timescale 1ns/1ps
`include "md_macros.svh"

module md_datapath
    import md_pkg::*;
(
    input  logic     clk,
    md_issue_if.dst  issue,
    input  logic     load,
    input  logic     step,
    input  logic     fix,
    md_cdb_if.src    out
);

    localparam int XLEN = `MD_XLEN;

    md_op_e                   op_q;
    logic                     is_div_q;
    logic                     neg_a_q;
    logic                     neg_b_q;
    logic                     div_zero_q;
    logic [XLEN-1:0]          opnd_q;
    // mul {upper, multiplier}, div {remainder, quotient}
    logic [2*XLEN-1:0]        work_q;
    logic [XLEN-1:0]          result_q;
    logic [`MD_PHY_BITS-1:0]  rd_q;
    logic [`MD_ROB_BITS-1:0]  rob_q;

    logic                     a_signed;
    logic                     b_signed;
    logic                     is_div;
    logic                     neg_a;
    logic                     neg_b;
    logic [XLEN-1:0]          mag_a;
    logic [XLEN-1:0]          mag_b;
    logic [XLEN:0]            mul_sum;
    logic [XLEN:0]            div_shift;
    logic [XLEN+1:0]          div_diff;
    logic [2*XLEN-1:0]        prod_fix;
    logic [XLEN-1:0]          quot_fix;
    logic [XLEN-1:0]          rem_fix;
    logic [XLEN-1:0]          fixed;

    // ------------------------------
    // operand signs and magnitudes
    // ------------------------------
    always_comb begin
        a_signed = issue.op inside {MD_MULH, MD_MULHSU, MD_DIV, MD_REM};
        b_signed = issue.op inside {MD_MULH, MD_DIV, MD_REM};
        is_div   = issue.op inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU};
        neg_a    = a_signed && issue.src1[XLEN-1];
        neg_b    = b_signed && issue.src2[XLEN-1];
        mag_a    = neg_a ? -issue.src1 : issue.src1;
        mag_b    = neg_b ? -issue.src2 : issue.src2;
    end

    // one shift-add or one restoring subtract per step
    always_comb begin
        mul_sum   = {1'b0, work_q[2*XLEN-1:XLEN]} + {1'b0, opnd_q};
        div_shift = {work_q[2*XLEN-1:XLEN], work_q[XLEN-1]};
        div_diff  = {1'b0, div_shift} - {2'b0, opnd_q};
    end

    // ------------------------------
    // sign fix-up and half select
    // ------------------------------
    // min / -1 falls out of the magnitude path, only x / 0 needs forcing
    always_comb begin
        prod_fix = (neg_a_q ^ neg_b_q) ? -work_q : work_q;
        quot_fix = (neg_a_q ^ neg_b_q) ? -work_q[XLEN-1:0] : work_q[XLEN-1:0];
        rem_fix  = neg_a_q ? -work_q[2*XLEN-1:XLEN] : work_q[2*XLEN-1:XLEN];
        case (op_q)
            MD_MUL:                       fixed = prod_fix[XLEN-1:0];
            MD_MULH, MD_MULHSU, MD_MULHU: fixed = prod_fix[2*XLEN-1:XLEN];
            MD_DIV, MD_DIVU:              fixed = div_zero_q ? '1 : quot_fix;
            default:                      fixed = rem_fix;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_q       <= issue.op;
            is_div_q   <= is_div;
            neg_a_q    <= neg_a;
            neg_b_q    <= neg_b;
            div_zero_q <= (issue.src2 == '0);
            rd_q       <= issue.rd_phy;
            rob_q      <= issue.rob_id;
            opnd_q     <= is_div ? mag_b : mag_a;
            work_q     <= {{XLEN{1'b0}}, is_div ? mag_a : mag_b};
        end else if (step) begin
            if (is_div_q) begin
                if (!div_diff[XLEN+1]) begin
                    work_q <= {div_diff[XLEN-1:0], work_q[XLEN-2:0], 1'b1};
                end else begin
                    work_q <= {div_shift[XLEN-1:0], work_q[XLEN-2:0], 1'b0};
                end
            end else if (work_q[0]) begin
                work_q <= {mul_sum, work_q[XLEN-1:1]};
            end else begin
                work_q <= {1'b0, work_q[2*XLEN-1:1]};
            end
        end
        if (fix) begin
            result_q <= fixed;
        end
    end

    assign out.rd_phy = rd_q;
    assign out.rob_id = rob_q;
    assign out.value  = result_q;

endmodule

// File: verilog/md_cycle_counter.sv
`timescale 1ns/1ps
`include "md_macros.svh"

module md_cycle_counter (
    input  logic  clk,
    input  logic  rst,
    input  logic  cnt_load,
    input  logic  cnt_en,
    output logic  cnt_last
);

    localparam int CNT_W = $clog2(`MD_XLEN);

    logic [CNT_W-1:0] count;

    // one count per iteration step
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (cnt_load) begin
            count <= CNT_W'(`MD_XLEN - 1);
        end else if (cnt_en) begin
            count <= count - 1'b1;
        end
    end

    assign cnt_last = (count == '0);

    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        cnt_en && !cnt_load |-> count != '0);

endmodule

// File: verilog/md_ctrl.sv
`timescale 1ns/1ps
`include "md_macros.svh"

module md_ctrl
    import md_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    md_issue_if.dst  issue,
    md_cdb_if.src    out,

    output logic     load,
    output logic     step,
    output logic     fix,
    output logic     cnt_load,
    output logic     cnt_en,
    input  logic     cnt_last
);

    md_state_e state;
    md_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        load       = 1'b0;
        step       = 1'b0;
        fix        = 1'b0;
        cnt_load   = 1'b0;
        cnt_en     = 1'b0;
        case (state)
            MD_IDLE: begin
                if (issue.valid) begin
                    load       = 1'b1;
                    cnt_load   = 1'b1;
                    state_next = MD_RUN;
                end
            end
            MD_RUN: begin
                step = 1'b1;
                // counter rests at zero on the final step
                cnt_en = !cnt_last;
                if (cnt_last) begin
                    state_next = MD_FIX;
                end
            end
            MD_FIX: begin
                fix        = 1'b1;
                state_next = MD_DONE;
            end
            default: begin
                if (out.ready) begin
                    state_next = MD_IDLE;
                end
            end
        endcase
    end

    assign issue.ready = (state == MD_IDLE);
    assign out.valid   = (state == MD_DONE);

    // issue to result latency through counter and datapath
    a_latency: assert property (@(posedge clk) disable iff (rst)
        load |-> ##(`MD_XLEN + 2) out.valid);

endmodule

// File: verilog/md_prf.sv
`timescale 1ns/1ps
`include "md_macros.svh"

module md_prf (
    input  logic        clk,
    md_cdb_if.snoop     ext_cdb,
    md_cdb_if.snoop     md_cdb,
    md_prf_read_if.rsp  rd
);

    logic [`MD_XLEN-1:0]  regs [2**`MD_PHY_BITS];
    logic                 ext_fire;
    logic                 md_fire;

    assign ext_fire = ext_cdb.valid && ext_cdb.ready;
    assign md_fire  = md_cdb.valid && md_cdb.ready;

    // own bus written last so it wins a tag collision
    always_ff @(posedge clk) begin
        if (ext_fire) begin
            regs[ext_cdb.rd_phy] <= ext_cdb.value;
        end
        if (md_fire) begin
            regs[md_cdb.rd_phy] <= md_cdb.value;
        end
    end

    // write-through bypass, same priority as the write
    always_comb begin
        rd.rs1_value = regs[rd.rs1_phy];
        rd.rs2_value = regs[rd.rs2_phy];
        if (ext_fire && ext_cdb.rd_phy == rd.rs1_phy) begin
            rd.rs1_value = ext_cdb.value;
        end
        if (ext_fire && ext_cdb.rd_phy == rd.rs2_phy) begin
            rd.rs2_value = ext_cdb.value;
        end
        if (md_fire && md_cdb.rd_phy == rd.rs1_phy) begin
            rd.rs1_value = md_cdb.value;
        end
        if (md_fire && md_cdb.rd_phy == rd.rs2_phy) begin
            rd.rs2_value = md_cdb.value;
        end
    end

endmodule

// File: verilog/md_rs.sv
`timescale 1ns/1ps
`include "md_macros.svh"

module md_rs
    import md_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        ds_valid,
    input  md_uop_t     ds_uop,
    output logic        ds_ready,

    md_cdb_if.snoop     ext_cdb,
    md_cdb_if.snoop     md_cdb,
    md_issue_if.src     issue,
    md_prf_read_if.req  prf
);

    md_uop_t                        entry [`MD_RS_DEPTH];
    logic [`MD_RS_DEPTH-1:0]        available;

    logic [2**`MD_PHY_BITS-1:0]     wake;
    md_uop_t                        pushed;
    logic                           push_en;
    logic [`MD_RS_IDX-1:0]          push_idx;
    logic                           issue_en;
    logic [`MD_RS_IDX-1:0]          issue_idx;
    logic [`MD_RS_DEPTH-1:0]        rs1_rdy;
    logic [`MD_RS_DEPTH-1:0]        rs2_rdy;

    // ------------------------------
    // wakeup from both result buses
    // ------------------------------
    always_comb begin
        wake = '0;
        if (ext_cdb.valid && ext_cdb.ready) begin
            wake[ext_cdb.rd_phy] = 1'b1;
        end
        if (md_cdb.valid && md_cdb.ready) begin
            wake[md_cdb.rd_phy] = 1'b1;
        end
    end

    // a same-cycle broadcast counts for the incoming uop too
    always_comb begin
        pushed = ds_uop;
        pushed.rs1_ready = ds_uop.rs1_ready | wake[ds_uop.rs1_phy];
        pushed.rs2_ready = ds_uop.rs2_ready | wake[ds_uop.rs2_phy];
    end

    // ------------------------------
    // push into lowest free entry
    // ------------------------------
    assign ds_ready = |available;
    assign push_en  = ds_valid && ds_ready;

    always_comb begin
        push_idx = '0;
        for (int i = `MD_RS_DEPTH - 1; i >= 0; i--) begin
            if (available[i]) begin
                push_idx = i[`MD_RS_IDX-1:0];
            end
        end
    end

    // ------------------------------
    // issue select picks the highest ready index
    // ------------------------------
    always_comb begin
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < `MD_RS_DEPTH; i++) begin
            rs1_rdy[i] = entry[i].rs1_ready | wake[entry[i].rs1_phy];
            rs2_rdy[i] = entry[i].rs2_ready | wake[entry[i].rs2_phy];
            if (!available[i] && rs1_rdy[i] && rs2_rdy[i]) begin
                issue_en  = 1'b1;
                issue_idx = i[`MD_RS_IDX-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            available <= '1;
        end else begin
            if (push_en) begin
                available[push_idx] <= 1'b0;
            end
            if (issue.valid && issue.ready) begin
                available[issue_idx] <= 1'b1;
            end
        end
    end

    // ready bits only matter while the entry is occupied
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MD_RS_DEPTH; i++) begin
            if (!available[i]) begin
                entry[i].rs1_ready <= rs1_rdy[i];
                entry[i].rs2_ready <= rs2_rdy[i];
            end
        end
        if (push_en) begin
            entry[push_idx] <= pushed;
        end
    end

    // operand read and issue fields
    assign prf.rs1_phy  = entry[issue_idx].rs1_phy;
    assign prf.rs2_phy  = entry[issue_idx].rs2_phy;
    assign issue.valid  = issue_en;
    assign issue.op     = entry[issue_idx].op;
    assign issue.rd_phy = entry[issue_idx].rd_phy;
    assign issue.rob_id = entry[issue_idx].rob_id;
    assign issue.src1   = prf.rs1_value;
    assign issue.src2   = prf.rs2_value;

    // a woken entry keeps its ready bits until the unit takes it
    a_issue_held: assert property (@(posedge clk) disable iff (rst)
        issue.valid && !issue.ready |=> issue.valid);

endmodule

// File: verilog/md_itf.sv
`timescale 1ns/1ps
`include "md_macros.svh"

// result bus, a broadcast counts on valid && ready
interface md_cdb_if;
    logic                     valid;
    logic                     ready;
    logic [`MD_PHY_BITS-1:0]  rd_phy;
    logic [`MD_ROB_BITS-1:0]  rob_id;
    logic [`MD_XLEN-1:0]      value;

    modport src (output valid, output rd_phy, output rob_id, output value, input ready);
    modport snoop (input valid, input ready, input rd_phy, input rob_id, input value);
endinterface

// station to execution unit
interface md_issue_if
    import md_pkg::*;
();
    logic                     valid;
    logic                     ready;
    md_op_e                   op;
    logic [`MD_PHY_BITS-1:0]  rd_phy;
    logic [`MD_ROB_BITS-1:0]  rob_id;
    logic [`MD_XLEN-1:0]      src1;
    logic [`MD_XLEN-1:0]      src2;

    modport src (output valid, output op, output rd_phy, output rob_id,
                 output src1, output src2, input ready);
    modport dst (input valid, input op, input rd_phy, input rob_id,
                 input src1, input src2, output ready);
endinterface

// operand read, values come back in the same cycle
interface md_prf_read_if;
    logic [`MD_PHY_BITS-1:0]  rs1_phy;
    logic [`MD_PHY_BITS-1:0]  rs2_phy;
    logic [`MD_XLEN-1:0]      rs1_value;
    logic [`MD_XLEN-1:0]      rs2_value;

    modport req (output rs1_phy, output rs2_phy, input rs1_value, input rs2_value);
    modport rsp (input rs1_phy, input rs2_phy, output rs1_value, output rs2_value);
endinterface

// File: verilog/md_pkg.sv
`include "md_macros.svh"

package md_pkg;

    // M-extension operations, multiplies first so bit 2 marks a divide
    typedef enum logic [2:0] {
        MD_MUL    = 3'd0,
        MD_MULH   = 3'd1,
        MD_MULHSU = 3'd2,
        MD_MULHU  = 3'd3,
        MD_DIV    = 3'd4,
        MD_DIVU   = 3'd5,
        MD_REM    = 3'd6,
        MD_REMU   = 3'd7
    } md_op_e;

    typedef enum logic [1:0] {
        MD_IDLE = 2'd0,
        MD_RUN  = 2'd1,
        MD_FIX  = 2'd2,
        MD_DONE = 2'd3
    } md_state_e;

    // renamed micro-op as held in a station entry
    typedef struct packed {
        md_op_e                   op;
        logic [`MD_PHY_BITS-1:0]  rs1_phy;
        logic                     rs1_ready;
        logic [`MD_PHY_BITS-1:0]  rs2_phy;
        logic                     rs2_ready;
        logic [`MD_PHY_BITS-1:0]  rd_phy;
        logic [`MD_ROB_BITS-1:0]  rob_id;
    } md_uop_t;

endpackage

// File: verilog/md_macros.svh
`ifndef MD_MACROS_SVH
`define MD_MACROS_SVH

// datapath width
`define MD_XLEN 32

// physical register tag, 32 registers
`define MD_PHY_BITS 5

`define MD_ROB_BITS 4

// reservation station size
`define MD_RS_DEPTH 4
`define MD_RS_IDX 2

`endif
